//--- zx_pkg.sv
// Spectrum core shared types, machine and turbo codes, memory map constants
package zx_pkg;

	// ========================================================================
	// Machine models
	// ========================================================================

	// Unknown memory model codes run as 128K
	typedef enum logic [2:0] {
		MACH_128   = 3'd0, // 128K/+2
		MACH_48    = 3'd3,
		MACH_PLUS3 = 3'd4
	} machine_t;

	// ========================================================================
	// CPU speed
	// ========================================================================

	// CPU period in clk_sys cycles is mask + 1
	typedef logic [4:0] turbo_t;

	localparam turbo_t TURBO_3M5 = 5'b11111; // original speed
	localparam turbo_t TURBO_7M  = 5'b01111;
	localparam turbo_t TURBO_14M = 5'b00111;
	localparam turbo_t TURBO_28M = 5'b00011;
	localparam turbo_t TURBO_56M = 5'b00001;

	// Other speed menu values mean original speed
	typedef logic [2:0] speed_sel_t;

	localparam speed_sel_t SPEED_7M  = 3'd1;
	localparam speed_sel_t SPEED_14M = 3'd2;
	localparam speed_sel_t SPEED_28M = 3'd3;
	localparam speed_sel_t SPEED_56M = 3'd4;

	localparam int SETTLE_EVENTS = 2; // settle timer width
	localparam int CNT_W         = 6; // clock enable counter width

	// ========================================================================
	// Memory map
	// ========================================================================

	localparam int RAM_ADDR_W = 25;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t; // SDRAM byte address

	localparam int PAGE_W = 14; // offset inside a 16K page

	localparam logic [2:0] ROM_REGION = 3'b101; // top bits of ROM area
	localparam logic [2:0] BANK_4000  = 3'd5;
	localparam logic [2:0] BANK_8000  = 3'd2;

endpackage

//--- paging_if.sv
// Page selection from the paging registers to the address mapper
interface paging_if;

	logic [2:0] ram_bank;    // bank at C000
	logic [3:0] rom_page;
	logic       special;     // +3 all-RAM mode
	logic [1:0] special_cfg; // 1FFD bits 2:1

	// Levels that move only on accepted port writes or reset

	modport producer (
		output ram_bank,
		output rom_page,
		output special,
		output special_cfg
	);

	modport consumer (
		input ram_bank,
		input rom_page,
		input special,
		input special_cfg
	);

endinterface

//--- clock_divider.sv
// Free-running counter producing the raw turbo CPU clock-enable pulses
module clock_divider (
	input  logic           clk_sys,
	input  logic           reset,
	input  zx_pkg::turbo_t turbo,
	output logic           cpu_p,
	output logic           cpu_n
);

	logic [zx_pkg::CNT_W-1:0] cnt;
	logic [zx_pkg::CNT_W-1:0] turbo_ext;
	logic [zx_pkg::CNT_W-1:0] phase;     // counter position inside one period
	logic [zx_pkg::CNT_W-1:0] half;      // mid point of the period

	assign turbo_ext = {{(zx_pkg::CNT_W - $bits(turbo)){1'b0}}, turbo};
	assign phase     = cnt & turbo_ext;

	// Mask is 2^k-1, so half period is its top bit alone
	assign half = turbo_ext ^ (turbo_ext >> 1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt   <= '0;
			cpu_p <= 1'b0;
			cpu_n <= 1'b0;
		end else begin
			cnt   <= cnt + 1'b1;
			cpu_p <= (phase == '0);   // rising CPU phase
			cpu_n <= (phase == half); // falling CPU phase
		end
	end

endmodule

//--- cpu_speed_ctrl.sv
// CPU speed switching, settle time, SDRAM wait and pause gating of the CPU clock
module cpu_speed_ctrl (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::speed_sel_t speed_sel,
	input  logic               pause,
	input  logic               ram_ready,
	input  logic               cpu_n,
	output zx_pkg::turbo_t     turbo,
	output logic               cpu_en
);

	typedef enum logic [1:0] {
		RUN,
		SETTLE,
		STALL
	} state_t;

	state_t                           state;
	logic [zx_pkg::SETTLE_EVENTS-1:0] settle_cnt;
	zx_pkg::turbo_t                   turbo_req;
	logic                             fast_turbo;

	// ========================================================================
	// Requested speed
	// ========================================================================

	always_comb begin
		case (speed_sel)
			zx_pkg::SPEED_7M:  turbo_req = zx_pkg::TURBO_7M;
			zx_pkg::SPEED_14M: turbo_req = zx_pkg::TURBO_14M;
			zx_pkg::SPEED_28M: turbo_req = zx_pkg::TURBO_28M;
			zx_pkg::SPEED_56M: turbo_req = zx_pkg::TURBO_56M;
			default:           turbo_req = zx_pkg::TURBO_3M5;
		endcase
	end

	// SDRAM can't keep up at 28 and 56 MHz
	assign fast_turbo = (turbo[4:2] == 3'b000);

	assign cpu_en = (state == RUN);

	// ========================================================================
	// State machine stepping on the falling CPU phase only
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= STALL; // waits for first ready event
			settle_cnt <= '0;
			turbo      <= zx_pkg::TURBO_3M5;
		end else if (cpu_n) begin
			if (turbo != turbo_req) begin
				// New speed stops the CPU while the clock settles
				state      <= SETTLE;
				turbo      <= turbo_req;
				settle_cnt <= {{(zx_pkg::SETTLE_EVENTS-1){1'b0}}, 1'b1};
			end else begin
				case (state)
					SETTLE: begin
						settle_cnt <= settle_cnt + 1'b1;
						if (settle_cnt == '1)
							state <= STALL; // third event after change
					end
					STALL: begin
						if (ram_ready && !pause)
							state <= RUN;
					end
					RUN: begin
						if (pause || (fast_turbo && !ram_ready))
							state <= STALL;
					end
					default: state <= STALL;
				endcase
			end
		end
	end

endmodule

//--- io_ports.sv
// I/O write decode for the 7FFD/1FFD paging registers and ULA port FE
module io_ports (
	input  logic             clk_sys,
	input  logic             reset,
	input  zx_pkg::machine_t machine,
	input  logic [15:0]      addr,
	input  logic [7:0]       cpu_dout,
	input  logic             iorq_n,
	input  logic             wr_n,
	input  logic             m1_n,
	paging_if.producer       pg,
	output logic             page_scr,
	output logic [2:0]       border_color,
	output logic             ear_out,
	output logic             mic_out
);

	zx_pkg::machine_t mach_q; // model taken at reset
	logic             is_48;
	logic             is_plus3;
	logic             io_wr;
	logic             io_wr_q;
	logic             io_wr_edge;
	logic             page_lock;
	logic             sel_7ffd;
	logic             sel_1ffd;
	logic             sel_fe;
	logic [5:0]       reg_7ffd;
	logic [2:0]       reg_1ffd;

	assign is_48    = (mach_q == zx_pkg::MACH_48);
	assign is_plus3 = (mach_q == zx_pkg::MACH_PLUS3);

	// I/O write outside interrupt acknowledge
	assign io_wr      = ~iorq_n & ~wr_n & m1_n;
	assign io_wr_edge = io_wr & ~io_wr_q;

	// 48K never pages and others stop once bit 5 is set
	assign page_lock = is_48 | reg_7ffd[5];

	// ========================================================================
	// Port decode
	// ========================================================================

	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3) & ~page_lock;
	assign sel_1ffd = ~addr[15] & ~addr[14] & ~addr[13] & addr[12] & ~addr[1]
		& is_plus3 & ~page_lock;
	assign sel_fe   = ~addr[0];

	always_ff @(posedge clk_sys) begin
		io_wr_q <= io_wr;

		if (reset) begin
			mach_q   <= machine;
			reg_7ffd <= '0;
			reg_1ffd <= '0;
			ear_out  <= 1'b0;
			mic_out  <= 1'b0;
		end else if (io_wr_edge) begin
			if (sel_7ffd)
				reg_7ffd <= cpu_dout[5:0];
			if (sel_1ffd)
				reg_1ffd <= cpu_dout[2:0];
			if (sel_fe) begin
				border_color <= cpu_dout[2:0];
				ear_out      <= cpu_dout[4];
				mic_out      <= cpu_dout[3];
			end
		end
	end

	// ========================================================================
	// Page outputs
	// ========================================================================

	always_comb begin
		case (mach_q)
			zx_pkg::MACH_48:    pg.rom_page = 4'b0111;
			zx_pkg::MACH_PLUS3: pg.rom_page = {2'b10, reg_1ffd[2], reg_7ffd[4]};
			default:            pg.rom_page = {3'b011, reg_7ffd[4]};
		endcase
	end

	assign pg.ram_bank    = reg_7ffd[2:0];
	assign pg.special     = reg_1ffd[0];   // all-RAM
	assign pg.special_cfg = reg_1ffd[2:1];
	assign page_scr       = reg_7ffd[3];   // shadow screen in bank 7

endmodule

//--- address_mapper.sv
// CPU memory cycle to SDRAM address, read and write enable translation
module address_mapper (
	input  logic              [15:0] addr,
	input  logic              mreq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	paging_if.consumer        pg,
	output zx_pkg::ram_addr_t ram_addr,
	output logic              ram_rd,
	output logic              ram_we
);

	logic       rom_sel; // quarter maps to ROM
	logic [2:0] bank;
	logic [1:0] cfg;

	assign cfg = pg.special_cfg;

	// ========================================================================
	// Bank per quarter
	// ========================================================================

	always_comb begin
		rom_sel = 1'b0;
		bank    = 3'd0;
		if (pg.special) begin
			// Layouts 0-1-2-3, 4-5-6-7, 4-5-6-3, 4-7-6-3
			case (addr[15:14])
				2'b00: bank = {|cfg, 2'b00};
				2'b01: bank = {|cfg, &cfg, 1'b1};
				2'b10: bank = {|cfg, 2'b10};
				2'b11: bank = {~cfg[1] & cfg[0], 2'b11};
			endcase
		end else begin
			case (addr[15:14])
				2'b00: rom_sel = 1'b1;
				2'b01: bank    = zx_pkg::BANK_4000;
				2'b10: bank    = zx_pkg::BANK_8000;
				2'b11: bank    = pg.ram_bank;
			endcase
		end
	end

	always_comb begin
		if (rom_sel)
			ram_addr = {{(zx_pkg::RAM_ADDR_W - 7 - zx_pkg::PAGE_W){1'b0}},
				zx_pkg::ROM_REGION, pg.rom_page, addr[zx_pkg::PAGE_W-1:0]};
		else
			ram_addr = {{(zx_pkg::RAM_ADDR_W - 3 - zx_pkg::PAGE_W){1'b0}},
				bank, addr[zx_pkg::PAGE_W-1:0]};
	end

	assign ram_rd = ~mreq_n & ~rd_n;
	assign ram_we = ~mreq_n & ~wr_n & ~rom_sel; // ROM is read only

endmodule

//--- zx_core.sv
// Spectrum CPU-side machine control top with clock enables, speed, paging and ULA port
module zx_core (
	input  logic               clk_sys,
	input  logic               reset,

	// CPU bus
	input  logic [15:0]        addr,
	input  logic [7:0]         cpu_dout,
	input  logic               mreq_n,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,

	// Configuration and memory status
	input  zx_pkg::machine_t   machine,
	input  zx_pkg::speed_sel_t speed_sel,
	input  logic               pause,
	input  logic               ram_ready,

	output logic               ce_cpu_p,
	output logic               ce_cpu_n,
	output logic               cpu_en,
	output zx_pkg::ram_addr_t  ram_addr,
	output logic               ram_rd,
	output logic               ram_we,
	output logic               page_scr,
	output logic [2:0]         border_color,
	output logic               ear_out,
	output logic               mic_out
);

	zx_pkg::turbo_t turbo;
	logic           cpu_p;
	logic           cpu_n;

	paging_if pg ();

	clock_divider clock_divider_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.turbo   (turbo),
		.cpu_p   (cpu_p),
		.cpu_n   (cpu_n)
	);

	cpu_speed_ctrl cpu_speed_ctrl_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.speed_sel (speed_sel),
		.pause     (pause),
		.ram_ready (ram_ready),
		.cpu_n     (cpu_n),
		.turbo     (turbo),
		.cpu_en    (cpu_en)
	);

	// CPU only sees phases while enabled
	assign ce_cpu_p = cpu_en & cpu_p;
	assign ce_cpu_n = cpu_en & cpu_n;

	io_ports io_ports_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.iorq_n       (iorq_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.pg           (pg.producer),
		.page_scr     (page_scr),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	address_mapper address_mapper_i (
		.addr     (addr),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.pg       (pg.consumer),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we)
	);

endmodule

//--- zx_core_assertions.sv
// Concurrent checks on the CPU clock enables and ROM write protection
module zx_core_assertions (
	input logic        clk_sys,
	input logic        reset,
	input logic        ce_cpu_p,
	input logic        ce_cpu_n,
	input logic        cpu_en,
	input logic        ram_we,
	input logic [15:0] addr,
	input logic        special
);
	timeunit 1ns;
	timeprecision 100ps;

	int assert_fails = 0; // failed assertion count

	// Both CPU phases in one cycle would clock the CPU twice
	phase_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n))
	else begin
		$error("ce_cpu_p and ce_cpu_n high in the same cycle");
		assert_fails++;
	end

	phase_gated: assert property (@(posedge clk_sys) disable iff (reset)
		!cpu_en |-> !ce_cpu_p && !ce_cpu_n)
	else begin
		$error("CPU clock enable while cpu_en is low");
		assert_fails++;
	end

	// ROM area is writable only in all-RAM mode
	rom_protect: assert property (@(posedge clk_sys) disable iff (reset)
		ram_we && addr[15:14] == 2'b00 |-> special)
	else begin
		$error("ram_we below 4000 outside special mode");
		assert_fails++;
	end

endmodule

bind zx_core zx_core_assertions zx_core_assertions_i (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.ce_cpu_p (ce_cpu_p),
	.ce_cpu_n (ce_cpu_n),
	.cpu_en   (cpu_en),
	.ram_we   (ram_we),
	.addr     (addr),
	.special  (pg.special)
);

//--- tb_zx_core.sv
// Testbench for the Spectrum core covering CPU clock enables, speed control, paging and ULA port
module tb_zx_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TEST_CYCLES     = 5000;              // rough length of all tests
	localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;
	localparam int EN_WAIT         = 250;               // worst settle is about 160 cycles

	logic               clk_sys;
	logic               reset;
	logic [15:0]        addr;
	logic [7:0]         cpu_dout;
	logic               mreq_n;
	logic               iorq_n;
	logic               rd_n;
	logic               wr_n;
	logic               m1_n;
	zx_pkg::machine_t   machine;
	zx_pkg::speed_sel_t speed_sel;
	logic               pause;
	logic               ram_ready;
	logic               ce_cpu_p;
	logic               ce_cpu_n;
	logic               cpu_en;
	zx_pkg::ram_addr_t  ram_addr;
	logic               ram_rd;
	logic               ram_we;
	logic               page_scr;
	logic [2:0]         border_color;
	logic               ear_out;
	logic               mic_out;

	int                 seed = 54171;
	string              test_name = "reset";
	logic               per_on;      // period checking enabled
	logic               p_seen;
	int                 last_p;
	int                 cyc = 0;
	int                 period;
	zx_pkg::machine_t   mmach;       // model of the paging state
	logic [5:0]         m7ffd;
	logic [2:0]         m1ffd;
	zx_pkg::speed_sel_t sel_list [8] = '{3'd1, 3'd2, 3'd3, 3'd4, 3'd7, 3'd0, 3'd5, 3'd6};

	zx_core zx_core_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Reference model and checking
	// ========================================================================

	function automatic zx_pkg::turbo_t ref_turbo(input zx_pkg::speed_sel_t s);
		case (s)
			3'd1:    return 5'b01111;
			3'd2:    return 5'b00111;
			3'd3:    return 5'b00011;
			3'd4:    return 5'b00001;
			default: return 5'b11111;
		endcase
	endfunction

	function automatic logic ref_special(input zx_pkg::machine_t mach, input logic [2:0] r1);
		return (mach == zx_pkg::MACH_PLUS3) && r1[0];
	endfunction

	function automatic zx_pkg::ram_addr_t ref_ram_addr(input zx_pkg::machine_t mach,
		input logic [5:0] r7, input logic [2:0] r1, input logic [15:0] a);
		logic [3:0] rom;
		logic [2:0] bank;
		logic [1:0] q;
		q = a[15:14];
		case (mach)
			zx_pkg::MACH_48:    rom = 4'b0111;
			zx_pkg::MACH_PLUS3: rom = {2'b10, r1[2], r7[4]};
			default:            rom = {3'b011, r7[4]};
		endcase
		if (ref_special(mach, r1)) begin
			case (r1[2:1])
				2'd0:    bank = {1'b0, q};                          // 0 1 2 3
				2'd1:    bank = {1'b1, q};                          // 4 5 6 7
				2'd2:    bank = (q == 2'd3) ? 3'd3 : {1'b1, q};     // 4 5 6 3
				default: bank = (q == 2'd1) ? 3'd7 : (q == 2'd3) ? 3'd3 : {1'b1, q};
			endcase
			return {8'd0, bank, a[13:0]};
		end
		case (q)
			2'd0:    return {4'd0, 3'b101, rom, a[13:0]};
			2'd1:    return {8'd0, 3'd5, a[13:0]};
			2'd2:    return {8'd0, 3'd2, a[13:0]};
			default: return {8'd0, r7[2:0], a[13:0]};
		endcase
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			fail_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
	endtask

	// Compares clock-enable spacing and every memory cycle
	always @(negedge clk_sys) begin
		if (zx_core_i.zx_core_assertions_i.assert_fails != 0)
			fail_run("a concurrent assertion failed inside zx_core");
		if (!per_on || !cpu_en || reset) begin
			p_seen = 1'b0; // stall or speed change breaks the spacing
		end else begin
			period = int'(ref_turbo(speed_sel)) + 1;
			if (ce_cpu_n && p_seen)
				check("ce_cpu_n half period", period / 2, cyc - last_p);
			if (ce_cpu_p) begin
				if (p_seen)
					check("ce_cpu_p period", period, cyc - last_p);
				last_p = cyc;
				p_seen = 1'b1;
			end
		end
		if (!reset) begin
			check({test_name, " ram_rd"}, !mreq_n && !rd_n, ram_rd);
			check({test_name, " ram_we"}, !mreq_n && !wr_n
				&& (ref_special(mmach, m1ffd) || addr[15:14] != 2'b00), ram_we);
		end
		if (!reset && !mreq_n)
			check({test_name, " ram_addr"}, ref_ram_addr(mmach, m7ffd, m1ffd, addr), ram_addr);
		cyc = cyc + 1;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		fail_run("watchdog expired before the test sequence finished");
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================

	task automatic next_drive_slot();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic do_reset(input zx_pkg::machine_t mach);
		next_drive_slot();
		machine = mach;
		reset   = 1'b1;
		repeat (10) next_drive_slot();
		reset = 1'b0;
		mmach = mach;
		m7ffd = '0;
		m1ffd = '0;
		@(negedge clk_sys);
		check("cpu_en after reset", 0, cpu_en);
		check("ear_out after reset", 0, ear_out);
		check("mic_out after reset", 0, mic_out);
	endtask

	task automatic wait_cpu_en(input logic level, input string what);
		for (int i = 0; i < EN_WAIT; i++) begin
			@(negedge clk_sys);
			if (cpu_en === level)
				return;
		end
		fail_run({"timeout waiting for cpu_en ", what});
	endtask

	task automatic wait_pulses(input int n);
		int seen;
		int waited;
		seen   = 0;
		waited = 0;
		while (seen < n) begin
			@(negedge clk_sys);
			waited++;
			if (ce_cpu_p)
				seen++;
			if (waited > 40 * n + 40)
				fail_run("ce_cpu_p pulses stopped while the CPU should run");
		end
	endtask

	task automatic count_pulses(input int cycles, output int np);
		np = 0;
		repeat (cycles) begin
			@(negedge clk_sys);
			if (ce_cpu_p)
				np++;
		end
	endtask

	task automatic change_speed(input zx_pkg::speed_sel_t s);
		logic changed;
		changed = (ref_turbo(s) != ref_turbo(speed_sel));
		next_drive_slot();
		per_on    = 1'b0;
		speed_sel = s;
		if (changed)
			wait_cpu_en(1'b0, "to drop after a speed change");
		wait_cpu_en(1'b1, "to rise after a speed change");
		next_drive_slot();
		per_on = 1'b1;
		wait_pulses(5);
	endtask

	task automatic stall_test(input string name, input logic use_pause);
		int np;
		next_drive_slot();
		if (use_pause)
			pause = 1'b1;
		else
			ram_ready = 1'b0;
		wait_cpu_en(1'b0, {"to drop for ", name});
		count_pulses(64, np);
		check({name, " pulses while stalled"}, 0, np);
		next_drive_slot();
		pause     = 1'b0;
		ram_ready = 1'b1;
		wait_cpu_en(1'b1, {"to return after ", name});
		wait_pulses(2);
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data);
		logic lock;
		next_drive_slot();
		addr     = port;
		cpu_dout = data;
		iorq_n   = 1'b0;
		wr_n     = 1'b0;
		next_drive_slot();
		cpu_dout = ~data; // a second write on a held strobe would show
		next_drive_slot();
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		lock   = (mmach == zx_pkg::MACH_48) || m7ffd[5];
		if (port == 16'h7FFD && !lock)
			m7ffd = data[5:0];
		if (port == 16'h1FFD && mmach == zx_pkg::MACH_PLUS3 && !lock)
			m1ffd = data[2:0];
		next_drive_slot();
	endtask

	task automatic mem_cycle(input logic [15:0] a, input logic write);
		next_drive_slot();
		addr     = a;
		cpu_dout = $random(seed);
		mreq_n   = 1'b0;
		rd_n     = write;
		wr_n     = !write;
		next_drive_slot();
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic all_quarters(input logic write);
		logic [15:0] r;
		for (int q = 0; q < 4; q++) begin
			r = $random(seed);
			mem_cycle({q[1:0], r[13:0]}, write);
		end
	endtask

	task automatic paging_round(input logic [7:0] d7);
		io_write(16'h7FFD, d7);
		check({test_name, " page_scr"}, m7ffd[3], page_scr);
		all_quarters(1'b0);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		logic [7:0]  d;
		logic [15:0] port;
		int          np;
		reset = 1'b1;
		addr = '0;
		cpu_dout = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		machine = zx_pkg::MACH_128;
		speed_sel = 3'd0;
		pause = 1'b0;
		ram_ready = 1'b1;
		per_on = 1'b0;
		do_reset(zx_pkg::MACH_128);

		test_name = "speed";
		wait_cpu_en(1'b1, "to rise after reset");
		next_drive_slot();
		per_on = 1'b1;
		wait_pulses(4);
		foreach (sel_list[i])
			change_speed(sel_list[i]);

		test_name = "stall";
		change_speed(3'd3);
		stall_test("28M SDRAM wait", 1'b0);
		change_speed(3'd4);
		stall_test("56M SDRAM wait", 1'b0);
		stall_test("56M pause", 1'b1);
		change_speed(3'd0);
		next_drive_slot();
		ram_ready = 1'b0;
		count_pulses(96, np); // three full periods at 3.5 MHz
		check("3M5 pulses with ram_ready low", 3, np);
		next_drive_slot();
		ram_ready = 1'b1;
		stall_test("3M5 pause", 1'b1);

		do_reset(zx_pkg::MACH_128);
		test_name = "128K paging";
		repeat (12) begin
			d = $random(seed);
			d[5] = 1'b0;
			paging_round(d);
		end
		paging_round($random(seed) | 8'h20); // lock
		repeat (4)
			paging_round($random(seed));

		do_reset(zx_pkg::MACH_48);
		test_name = "48K paging";
		repeat (6)
			paging_round($random(seed));

		do_reset(zx_pkg::MACH_PLUS3);
		test_name = "+3 paging";
		for (int i = 0; i < 8; i++) begin
			d = $random(seed);
			d[5] = 1'b0;
			d[4] = i[0];
			io_write(16'h7FFD, d);
			io_write(16'h1FFD, i[2] ? {5'd0, i[1:0], 1'b1} : {5'd0, i[1], 2'b00});
			all_quarters(1'b0);
			all_quarters(1'b1);
		end

		test_name = "ULA";
		repeat (4) begin
			d = $random(seed);
			port = $random(seed);
			io_write({port[15:8], 8'hFE}, d);
			check("border_color", d[2:0], border_color);
			check("ear_out", d[4], ear_out);
			check("mic_out", d[3], mic_out);
		end
		io_write(16'hFFFE, 8'h18); // ear and mic high before the reset
		check("ear_out", 1, ear_out);
		check("mic_out", 1, mic_out);
		do_reset(zx_pkg::MACH_128);

		if (zx_core_i.zx_core_assertions_i.assert_fails != 0) begin
			fail_run("a concurrent assertion failed inside zx_core");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- verilog.f
zx_pkg.sv
paging_if.sv
clock_divider.sv
cpu_speed_ctrl.sv
io_ports.sv
address_mapper.sv
zx_core.sv
zx_core_assertions.sv
tb_zx_core.sv
